// File: Makefile
TOP := fma_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "simulation ended early"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module fma_top

clean:
	rm -rf obj_dir sim.log

// File: dv/fma_vectors.svh
`ifndef FMA_VECTORS_SVH
`define FMA_VECTORS_SVH

// columns: name, a, b, c, sub, rnd, then expected u_result, rs, round_en, invalid, overflow

typedef struct packed {
    fma_pkg::fp32_t       a;
    fma_pkg::fp32_t       b;
    fma_pkg::fp32_t       c;
    logic                 sub;
    fma_pkg::roundmode_e  rnd;
    fma_pkg::fma_result_t expected;
} vector_t;

localparam int unsigned NUM_VECTORS = 23;

string       vec_name [NUM_VECTORS];
vector_t     vec      [NUM_VECTORS];
int unsigned row_count = 0;

task automatic add_row(input string name, input fma_pkg::fp32_t a, input fma_pkg::fp32_t b,
                       input fma_pkg::fp32_t c, input logic sub, input fma_pkg::roundmode_e rnd,
                       input fma_pkg::fp32_t u_result, input logic [1:0] rs,
                       input logic round_en, input logic invalid, input logic overflow);
    if (row_count < NUM_VECTORS)
    begin
        vec_name[row_count] = name;
        vec[row_count]      = {a, b, c, sub, rnd, u_result, rs, round_en, invalid, overflow};
    end
    row_count++;
endtask

task automatic load_table();
    // exact results
    add_row("exact_add",     32'h3fc0_0000, 32'h4000_0000, 32'h3f80_0000, 1'b0, fma_pkg::RNE,
            32'h4080_0000, 2'b00, 1'b1, 1'b0, 1'b0);
    add_row("exact_sub",     32'h4040_0000, 32'h4000_0000, 32'h3f80_0000, 1'b1, fma_pkg::RNE,
            32'h40a0_0000, 2'b00, 1'b1, 1'b0, 1'b0);
    add_row("neg_c",         32'h4000_0000, 32'h4000_0000, 32'hc100_0000, 1'b0, fma_pkg::RTZ,
            32'hc080_0000, 2'b00, 1'b1, 1'b0, 1'b0);
    add_row("neg_prod_sub",  32'hbfc0_0000, 32'h4080_0000, 32'h4000_0000, 1'b1, fma_pkg::RUP,
            32'hc100_0000, 2'b00, 1'b1, 1'b0, 1'b0);
    // inexact, truncated with guard and sticky
    add_row("sticky_only",   32'h3f80_0000, 32'h3f80_0000, 32'h3080_0000, 1'b0, fma_pkg::RNE,
            32'h3f80_0000, 2'b01, 1'b1, 1'b0, 1'b0);
    add_row("guard_only",    32'h3f80_0000, 32'h3f80_0000, 32'h3380_0000, 1'b0, fma_pkg::RNE,
            32'h3f80_0000, 2'b10, 1'b1, 1'b0, 1'b0);
    add_row("sub_borrow",    32'h3f80_0000, 32'h3f80_0000, 32'h3080_0000, 1'b1, fma_pkg::RMM,
            32'h3f7f_ffff, 2'b11, 1'b1, 1'b0, 1'b0);
    add_row("product_lsbs",  32'h3f80_0001, 32'h3f80_0001, 32'h0000_0000, 1'b0, fma_pkg::RNE,
            32'h3f80_0002, 2'b01, 1'b1, 1'b0, 1'b0);
    // special values
    add_row("inf_times_0",   32'h7f80_0000, 32'h0000_0000, 32'h3f80_0000, 1'b0, fma_pkg::RNE,
            32'hffc0_0000, 2'b00, 1'b0, 1'b1, 1'b0);
    add_row("inf_minus_inf", 32'h7f80_0000, 32'h3f80_0000, 32'h7f80_0000, 1'b1, fma_pkg::RNE,
            32'hffc0_0000, 2'b00, 1'b0, 1'b1, 1'b0);
    add_row("nan_a_first",   32'h7fc0_0001, 32'h7fc0_0002, 32'h7fc0_0003, 1'b0, fma_pkg::RNE,
            32'h7fc0_0001, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("nan_b_second",  32'h3f80_0000, 32'hffc1_2345, 32'h7fc0_0007, 1'b0, fma_pkg::RNE,
            32'hffc1_2345, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("nan_c_last",    32'h4000_0000, 32'h4040_0000, 32'h7fc0_0ab0, 1'b0, fma_pkg::RNE,
            32'h7fc0_0ab0, 2'b00, 1'b0, 1'b0, 1'b0);
    // signalling nan comes out quiet with its payload
    add_row("snan_a_quiet",  32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, 1'b0, fma_pkg::RNE,
            32'h7fc0_0001, 2'b00, 1'b0, 1'b1, 1'b0);
    add_row("inf_c_sub",     32'h4000_0000, 32'h4040_0000, 32'h7f80_0000, 1'b1, fma_pkg::RNE,
            32'hff80_0000, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("inf_product",   32'hff80_0000, 32'h4000_0000, 32'h3f80_0000, 1'b0, fma_pkg::RNE,
            32'hff80_0000, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("subnorm_a",     32'h8000_0001, 32'h4000_0000, 32'h8000_0000, 1'b0, fma_pkg::RNE,
            32'h8000_0000, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("subnorm_c",     32'h3fc0_0000, 32'h4000_0000, 32'h0040_0000, 1'b0, fma_pkg::RNE,
            32'h4040_0000, 2'b00, 1'b1, 1'b0, 1'b0);
    // overflow and zeros
    add_row("overflow_pos",  32'h7f00_0000, 32'h7f00_0000, 32'h3f80_0000, 1'b0, fma_pkg::RNE,
            32'h7f80_0000, 2'b00, 1'b0, 1'b0, 1'b1);
    add_row("overflow_neg",  32'hff00_0000, 32'h7f00_0000, 32'h3f80_0000, 1'b0, fma_pkg::RNE,
            32'hff80_0000, 2'b00, 1'b0, 1'b0, 1'b1);
    add_row("cancel_rne",    32'h4000_0000, 32'h4040_0000, 32'h40c0_0000, 1'b1, fma_pkg::RNE,
            32'h0000_0000, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("cancel_rdn",    32'h4000_0000, 32'h4040_0000, 32'h40c0_0000, 1'b1, fma_pkg::RDN,
            32'h8000_0000, 2'b00, 1'b0, 1'b0, 1'b0);
    add_row("tiny_negative", 32'h8d80_0000, 32'h0d80_0000, 32'h0000_0000, 1'b0, fma_pkg::RNE,
            32'h8000_0000, 2'b00, 1'b0, 1'b0, 1'b0);
endtask

`endif

// File: dv/fma_tb.sv
module fma_tb;

localparam int unsigned QUEUE_DEPTH = 4;
localparam int unsigned OUT_CREDITS = 2;

logic                 clk_i;
logic                 rst_i;
fma_pkg::fp32_t       a_i;
fma_pkg::fp32_t       b_i;
fma_pkg::fp32_t       c_i;
logic                 sub_i;
fma_pkg::roundmode_e  rnd_i;
logic                 start_i;
logic                 in_credit_o;
fma_pkg::fma_result_t result_o;
logic                 done_o;
logic                 out_credit_i;

`include "fma_vectors.svh"

localparam int unsigned TIMEOUT_CYCLES = 20 * NUM_VECTORS + 100;

fma_top
#(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
)
dut
(
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .c_i          (c_i),
    .sub_i        (sub_i),
    .rnd_i        (rnd_i),
    .start_i      (start_i),
    .in_credit_o  (in_credit_o),
    .result_o     (result_o),
    .done_o       (done_o),
    .out_credit_i (out_credit_i)
);

//////////////////////////////////////////////////////////////////////
// helpers
//////////////////////////////////////////////////////////////////////

task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1);
endtask

task automatic expect_idle(input string phase);
    assert (done_o === 1'b0 && in_credit_o === 1'b0)
    else
    begin
        $display("done_o or in_credit_o is not low %s", phase);
        stop_with_failure();
    end
endtask

task automatic expect_value(input string test, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
        $display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
        stop_with_failure();
    end
endtask

task automatic compare_result(input int unsigned n);
    fma_pkg::fma_result_t exp_r;
    fma_pkg::fma_result_t act_r;
    exp_r = vec[n].expected;
    act_r = result_o;
    expect_value(vec_name[n], "u_result", exp_r.u_result, act_r.u_result);
    expect_value(vec_name[n], "rs", 32'(exp_r.rs), 32'(act_r.rs));
    expect_value(vec_name[n], "round_en", 32'(exp_r.round_en), 32'(act_r.round_en));
    expect_value(vec_name[n], "invalid", 32'(exp_r.invalid), 32'(act_r.invalid));
    expect_value(vec_name[n], "overflow", 32'(exp_r.overflow), 32'(act_r.overflow));
endtask

//////////////////////////////////////////////////////////////////////
// clock, reset and stimulus
//////////////////////////////////////////////////////////////////////

initial
begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
end

initial
begin : drive_inputs
    int unsigned idx;
    logic        have_credit;
    rst_i   = 1'b1;
    start_i = 1'b0;
    a_i     = '0;
    b_i     = '0;
    c_i     = '0;
    sub_i   = 1'b0;
    rnd_i   = fma_pkg::RNE;
    load_table();
    assert (row_count == NUM_VECTORS)
    else
    begin
        $display("vector table holds %0d rows instead of %0d", row_count, NUM_VECTORS);
        stop_with_failure();
    end

    for (int cyc = 0; cyc < 8; cyc++)
    begin
        @(posedge clk_i);
        if (cyc > 0)
            expect_idle("during reset");
    end
    rst_i <= 1'b0;
    @(posedge clk_i);
    expect_idle("right after reset");

    // upstream holds one credit after reset
    have_credit = 1'b1;
    idx         = 0;
    while (idx < NUM_VECTORS)
    begin
        if (have_credit)
        begin
            a_i         <= vec[idx].a;
            b_i         <= vec[idx].b;
            c_i         <= vec[idx].c;
            sub_i       <= vec[idx].sub;
            rnd_i       <= vec[idx].rnd;
            start_i     <= 1'b1;
            have_credit = 1'b0;
            idx++;
        end
        else
            start_i <= 1'b0;
        @(posedge clk_i);
        if (in_credit_o === 1'b1)
            have_credit = 1'b1;
    end
    start_i <= 1'b0;
end

//////////////////////////////////////////////////////////////////////
// downstream credits, checking and timeout
//////////////////////////////////////////////////////////////////////

initial
begin : return_credits
    int          seed;
    int unsigned now;
    int unsigned dones;
    int unsigned returned;
    int unsigned delay;
    int unsigned due [$];
    int          hit;
    seed         = 32'h40e381ed;
    now          = 0;
    dones        = 0;
    returned     = 0;
    out_credit_i = 1'b0;
    forever
    begin
        @(posedge clk_i);
        now++;
        if (done_o === 1'b1)
        begin
            dones++;
            assert (dones <= OUT_CREDITS + returned)
            else
            begin
                $display("done_o raised with no output credit left after %0d results", dones);
                stop_with_failure();
            end
            delay = $unsigned($random(seed)) % 6;
            due.push_back(now + delay);
        end
        // one credit back per cycle at most
        hit = -1;
        for (int k = 0; k < due.size(); k++)
        begin
            if (hit < 0 && due[k] <= now)
                hit = k;
        end
        if (hit >= 0)
        begin
            due.delete(hit);
            out_credit_i <= 1'b1;
            returned++;
        end
        else
            out_credit_i <= 1'b0;
    end
end

initial
begin : check_results
    int unsigned n;
    n = 0;
    while (n < NUM_VECTORS)
    begin
        @(posedge clk_i);
        if (done_o === 1'b1)
        begin
            compare_result(n);
            n++;
        end
    end
    $display("TEST PASS");
    $finish;
end

initial
begin : watchdog
    int unsigned cycles;
    cycles = 0;
    forever
    begin
        @(posedge clk_i);
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("simulation timed out after %0d cycles without all results", cycles);
            stop_with_failure();
        end
    end
end

endmodule

// File: verilog.f
+incdir+dv
verilog/fma_pkg.sv
verilog/fma_mul_stage.sv
verilog/fma_product_queue.sv
verilog/fma_add_stage.sv
verilog/fma_top.sv
dv/fma_tb.sv

// File: verilog/fma_add_stage.sv
module fma_add_stage
#(
    parameter int unsigned OUT_CREDITS = 2
)
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 head_valid_i,
    input  fma_pkg::product_t    head_item_i,
    input  logic                 out_credit_i,
    output logic                 pop_o,
    output fma_pkg::fma_result_t result_o,
    output logic                 done_o
);

localparam int unsigned CW      = $clog2(OUT_CREDITS + 1);
localparam int unsigned PROD_W  = 2*fma_pkg::MANT_W + 2;
localparam int unsigned ALN_W   = PROD_W + fma_pkg::GUARD_W;
// product width plus guard bits, sticky lsb and one carry bit
localparam int unsigned SUM_W   = ALN_W + 2;
localparam int unsigned ONE_POS = SUM_W - 3;

function automatic logic [5:0] lzc(input logic [SUM_W-1:0] v);
    logic [5:0] cnt;
    logic       found;
    cnt   = 6'(SUM_W);
    found = 1'b0;
    for (int i = SUM_W - 1; i >= 0; i--)
    begin
        if (!found && v[i])
        begin
            cnt   = 6'(SUM_W - 1 - i);
            found = 1'b1;
        end
    end
    return cnt;
endfunction

fma_pkg::product_t h;
assign h = head_item_i;

//////////////////////////////////////////////////////////////////////
// align
//////////////////////////////////////////////////////////////////////

logic                  c_eff_sign;
fma_pkg::prod_mant_t   c_sig;
fma_pkg::wide_exp_t    c_exp;
logic                  use_c;
fma_pkg::wide_exp_t    big_exp;
fma_pkg::wide_exp_t    exp_diff;
logic [5:0]            shamt;
fma_pkg::prod_mant_t   big_sig;
fma_pkg::prod_mant_t   small_sig;
logic [2*ALN_W-1:0]    small_ext;
logic                  sticky;

assign c_eff_sign = h.sign ^ h.eff_sub;
assign c_sig      = h.c_class.is_zero ? '0 : {2'b01, h.c.mant, {fma_pkg::MANT_W{1'b0}}};
assign c_exp      = {2'b00, h.c.exp};

// a zero product never leads
assign use_c     = h.ab_class.is_zero | (!h.c_class.is_zero & (c_exp > h.exp));
assign big_exp   = use_c ? c_exp : h.exp;
assign exp_diff  = use_c ? (c_exp - h.exp) : (h.exp - c_exp);
assign shamt     = (exp_diff < 0 || exp_diff > 63) ? 6'd63 : exp_diff[5:0];
assign big_sig   = use_c ? c_sig : h.mant;
assign small_sig = use_c ? h.mant : c_sig;

assign small_ext = {small_sig, {fma_pkg::GUARD_W{1'b0}}, {ALN_W{1'b0}}} >> shamt;
assign sticky    = |small_ext[ALN_W-1:0];

//////////////////////////////////////////////////////////////////////
// add and normalize
//////////////////////////////////////////////////////////////////////

logic [SUM_W-2:0]    op_big;
logic [SUM_W-2:0]    op_small;
logic [SUM_W:0]      raw;
logic [SUM_W:0]      mag_full;
logic [SUM_W-1:0]    mag;
logic                neg;
logic                sum_sign;
logic [5:0]          lz;
logic [SUM_W-1:0]    norm;
logic                lost;
fma_pkg::wide_exp_t  norm_exp;
logic                sum_zero;

assign op_big   = {big_sig, {fma_pkg::GUARD_W{1'b0}}, 1'b0};
assign op_small = {small_ext[2*ALN_W-1:ALN_W], sticky};

assign raw = h.eff_sub ? ({2'b00, op_big} - {2'b00, op_small})
                       : ({2'b00, op_big} + {2'b00, op_small});

// equal exponents can still leave c ahead
assign neg      = h.eff_sub & raw[SUM_W];
assign mag_full = neg ? -raw : raw;
assign mag      = mag_full[SUM_W-1:0];
assign sum_sign = (use_c ? c_eff_sign : h.sign) ^ neg;
assign sum_zero = (mag == '0);
assign lz       = lzc(mag);

always_comb
begin
    lost = 1'b0;
    if (lz < 6'd2)
    begin
        // carry out, shift right into place
        norm = mag >> (6'd2 - lz);
        lost = (lz == 6'd0) ? |mag[1:0] : mag[0];
    end
    else
        norm = mag << (lz - 6'd2);
end

assign norm_exp = big_exp + 10'sd2 - $signed({4'b0000, lz});

//////////////////////////////////////////////////////////////////////
// special cases and result
//////////////////////////////////////////////////////////////////////

fma_pkg::fma_result_t res_d;
logic                 op_invalid;

// inf times zero, or infinities of opposite effective sign
assign op_invalid = (h.ab_class.is_inf & h.ab_class.is_zero)
                  | (h.ab_class.is_inf & !h.ab_class.is_nan & h.c_class.is_inf & h.eff_sub);

always_comb
begin
    res_d          = '0;
    res_d.invalid  = h.invalid;
    if (op_invalid)
        res_d.u_result = fma_pkg::QNAN_DEFAULT;
    else if (h.ab_class.is_nan)
        res_d.u_result = {h.sign, {fma_pkg::EXP_W{1'b1}}, 1'b1,
                          h.mant[2*fma_pkg::MANT_W-2 -: fma_pkg::MANT_W-1]};
    else if (h.c_class.is_nan)
        res_d.u_result = {h.c.sign, {fma_pkg::EXP_W{1'b1}}, 1'b1,
                          h.c.mant[fma_pkg::MANT_W-2:0]};
    else if (h.ab_class.is_inf)
        res_d.u_result = {h.sign, {fma_pkg::EXP_W{1'b1}}, {fma_pkg::MANT_W{1'b0}}};
    else if (h.c_class.is_inf)
        res_d.u_result = {c_eff_sign, {fma_pkg::EXP_W{1'b1}}, {fma_pkg::MANT_W{1'b0}}};
    else if (!sum_zero && norm_exp > 10'sd254)
    begin
        res_d.u_result = {sum_sign, {fma_pkg::EXP_W{1'b1}}, {fma_pkg::MANT_W{1'b0}}};
        res_d.overflow = 1'b1;
    end
    else if (sum_zero)
    begin
        // like signs keep their sign, a true cancellation depends on the mode
        res_d.u_result.sign = (h.sign == c_eff_sign) ? h.sign : (h.rnd == fma_pkg::RDN);
    end
    else if (norm_exp < 10'sd1)
        res_d.u_result.sign = sum_sign;
    else
    begin
        res_d.u_result = {sum_sign, norm_exp[fma_pkg::EXP_W-1:0],
                          norm[ONE_POS-1 -: fma_pkg::MANT_W]};
        res_d.rs       = {norm[ONE_POS-fma_pkg::MANT_W-1],
                          |norm[ONE_POS-fma_pkg::MANT_W-2:0] | lost | sticky};
        res_d.round_en = 1'b1;
    end
end

//////////////////////////////////////////////////////////////////////
// output credits
//////////////////////////////////////////////////////////////////////

logic [CW-1:0] credits_q;
// results handed out and not yet credited back
logic [CW-1:0] in_use_q;

assign pop_o = head_valid_i && (credits_q != '0);

always_ff @(posedge clk_i)
begin
    if (rst_i)
    begin
        credits_q <= CW'(OUT_CREDITS);
        in_use_q  <= '0;
        done_o    <= 1'b0;
    end
    else
    begin
        credits_q <= credits_q - CW'(pop_o) + CW'(out_credit_i);
        in_use_q  <= in_use_q + CW'(done_o) - CW'(out_credit_i);
        done_o    <= pop_o;
    end
end

always_ff @(posedge clk_i)
begin
    if (pop_o)
        result_o <= res_d;
end

a_done_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |-> in_use_q < CW'(OUT_CREDITS));

// downstream never returns more than it consumed
a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    credits_q <= CW'(OUT_CREDITS));

endmodule

// File: verilog/fma_mul_stage.sv
module fma_mul_stage
#(
    parameter int unsigned QUEUE_DEPTH = 4
)
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  fma_pkg::fp32_t        a_i,
    input  fma_pkg::fp32_t        b_i,
    input  fma_pkg::fp32_t        c_i,
    input  logic                  sub_i,
    input  fma_pkg::roundmode_e   rnd_i,
    input  logic                  start_i,
    input  logic                  pop_credit_i,
    output logic                  push_o,
    output fma_pkg::product_t     push_item_o,
    output logic                  in_credit_o
);

localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);

// subnormals read as zero
function automatic fma_pkg::fp_class_t classify(input fma_pkg::fp32_t x);
    fma_pkg::fp_class_t cls;
    cls.is_zero = (x.exp == '0);
    cls.is_inf  = (x.exp == '1) && (x.mant == '0);
    cls.is_nan  = (x.exp == '1) && (x.mant != '0);
    cls.is_snan = cls.is_nan && !x.mant[fma_pkg::MANT_W-1];
    return cls;
endfunction

fma_pkg::fp_class_t a_cls;
fma_pkg::fp_class_t b_cls;
fma_pkg::fp_class_t c_cls;

assign a_cls = classify(a_i);
assign b_cls = classify(b_i);
assign c_cls = classify(c_i);

//////////////////////////////////////////////////////////////////////
// product
//////////////////////////////////////////////////////////////////////

logic [fma_pkg::MANT_W:0] sig_a;
logic [fma_pkg::MANT_W:0] sig_b;
fma_pkg::wide_exp_t       a_exp_w;
fma_pkg::wide_exp_t       b_exp_w;
logic                     prod_sign;
fma_pkg::product_t        item_d;

assign sig_a   = a_cls.is_zero ? '0 : {1'b1, a_i.mant};
assign sig_b   = b_cls.is_zero ? '0 : {1'b1, b_i.mant};
assign a_exp_w = {2'b00, a_i.exp};
assign b_exp_w = {2'b00, b_i.exp};
assign prod_sign = a_i.sign ^ b_i.sign;

always_comb
begin
    item_d.sign     = prod_sign;
    item_d.exp      = a_exp_w + b_exp_w - fma_pkg::wide_exp_t'(fma_pkg::BIAS);
    item_d.mant     = sig_a * sig_b;
    item_d.ab_class.is_zero = a_cls.is_zero | b_cls.is_zero;
    item_d.ab_class.is_inf  = a_cls.is_inf  | b_cls.is_inf;
    item_d.ab_class.is_nan  = a_cls.is_nan  | b_cls.is_nan;
    item_d.ab_class.is_snan = a_cls.is_snan | b_cls.is_snan;
    item_d.c        = c_i;
    item_d.c_class  = c_cls;
    item_d.eff_sub  = prod_sign ^ c_i.sign ^ sub_i;
    item_d.rnd      = rnd_i;
    item_d.invalid  = a_cls.is_snan | b_cls.is_snan | c_cls.is_snan
                    | (a_cls.is_inf & b_cls.is_zero) | (a_cls.is_zero & b_cls.is_inf)
                    | (!a_cls.is_nan & !b_cls.is_nan & (a_cls.is_inf | b_cls.is_inf)
                       & c_cls.is_inf & item_d.eff_sub);

    // nan payload rides in the fraction field, a wins over b
    if (a_cls.is_nan)
    begin
        item_d.sign = a_i.sign;
        item_d.mant = {2'b01, a_i.mant, {fma_pkg::MANT_W{1'b0}}};
    end
    else if (b_cls.is_nan)
    begin
        item_d.sign = b_i.sign;
        item_d.mant = {2'b01, b_i.mant, {fma_pkg::MANT_W{1'b0}}};
    end
end

//////////////////////////////////////////////////////////////////////
// holding register and queue credits
//////////////////////////////////////////////////////////////////////

logic              full_q;
logic [CW-1:0]     credits_q;
fma_pkg::product_t item_q;

assign push_o      = full_q && (credits_q != '0);
assign push_item_o = item_q;
assign in_credit_o = push_o;

always_ff @(posedge clk_i)
begin
    if (rst_i)
    begin
        full_q    <= 1'b0;
        credits_q <= CW'(QUEUE_DEPTH);
    end
    else
    begin
        if (start_i)
            full_q <= 1'b1;
        else if (push_o)
            full_q <= 1'b0;
        credits_q <= credits_q - CW'(push_o) + CW'(pop_credit_i);
    end
end

always_ff @(posedge clk_i)
begin
    if (start_i)
        item_q <= item_d;
end

// upstream only starts with its single credit in hand
a_start_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> !full_q);

a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    credits_q <= CW'(QUEUE_DEPTH));

endmodule

// File: verilog/fma_pkg.sv
package fma_pkg;

    //////////////////////////////////////////////////////////////////////
    // format widths
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned EXP_W   = 8;
    localparam int unsigned MANT_W  = 23;
    localparam int unsigned BIAS    = 127;

    // extra bits kept below the product lsb while aligning
    localparam int unsigned GUARD_W = 3;

    typedef logic [EXP_W-1:0]      exp_t;
    typedef logic [MANT_W-1:0]     mant_t;

    // 24 x 24 significand product, 1.0 sits at bit 46
    typedef logic [2*MANT_W+1:0]   prod_mant_t;

    // signed, room for exponents above 255 and below 1
    typedef logic signed [EXP_W+1:0] wide_exp_t;

    //////////////////////////////////////////////////////////////////////
    // operand and class
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
    } fp32_t;

    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_snan;
    } fp_class_t;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } roundmode_e;

    // negative quiet nan, same pattern as the x86 indefinite
    localparam fp32_t QNAN_DEFAULT = 32'hffc0_0000;

    //////////////////////////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////////////////////////

    // one multiply result waiting for its addend
    typedef struct packed {
        logic       sign;
        wide_exp_t  exp;
        prod_mant_t mant;      // holds nan payload when ab_class.is_nan
        fp_class_t  ab_class;
        fp32_t      c;
        fp_class_t  c_class;
        logic       eff_sub;
        roundmode_e rnd;
        logic       invalid;
    } product_t;

    typedef struct packed {
        fp32_t      u_result;
        logic [1:0] rs;
        logic       round_en;
        logic       invalid;
        logic       overflow;
    } fma_result_t;

endpackage

// File: verilog/fma_product_queue.sv
module fma_product_queue
#(
    parameter int unsigned QUEUE_DEPTH = 4
)
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              push_i,
    input  fma_pkg::product_t push_item_i,
    input  logic              pop_i,
    output logic              head_valid_o,
    output fma_pkg::product_t head_item_o,
    output logic              pop_credit_o
);

localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

fma_pkg::product_t mem [QUEUE_DEPTH];

logic [PTR_W-1:0] wr_ptr_q;
logic [PTR_W-1:0] rd_ptr_q;
logic [CNT_W-1:0] count_q;

// show-ahead head
assign head_valid_o = (count_q != '0);
assign head_item_o  = mem[rd_ptr_q];

always_ff @(posedge clk_i)
begin
    if (rst_i)
    begin
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
        count_q      <= '0;
        pop_credit_o <= 1'b0;
    end
    else
    begin
        if (push_i)
        begin
            if (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1))
                wr_ptr_q <= '0;
            else
                wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop_i)
        begin
            if (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1))
                rd_ptr_q <= '0;
            else
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        count_q      <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
        // one credit back per freed slot
        pop_credit_o <= pop_i;
    end
end

always_ff @(posedge clk_i)
begin
    if (push_i)
        mem[wr_ptr_q] <= push_item_i;
end

a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> count_q != CNT_W'(QUEUE_DEPTH));

a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> count_q != '0);

endmodule

// File: verilog/fma_top.sv
module fma_top
#(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned OUT_CREDITS = 2
)
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  fma_pkg::fp32_t       a_i,
    input  fma_pkg::fp32_t       b_i,
    input  fma_pkg::fp32_t       c_i,
    input  logic                 sub_i,
    input  fma_pkg::roundmode_e  rnd_i,
    input  logic                 start_i,
    output logic                 in_credit_o,
    output fma_pkg::fma_result_t result_o,
    output logic                 done_o,
    input  logic                 out_credit_i
);

logic              push;
fma_pkg::product_t push_item;
logic              pop_credit;
logic              pop;
logic              head_valid;
fma_pkg::product_t head_item;

// multiply
fma_mul_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_mul
(
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .c_i          (c_i),
    .sub_i        (sub_i),
    .rnd_i        (rnd_i),
    .start_i      (start_i),
    .pop_credit_i (pop_credit),
    .push_o       (push),
    .push_item_o  (push_item),
    .in_credit_o  (in_credit_o)
);

fma_product_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue
(
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (push),
    .push_item_i  (push_item),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_item_o  (head_item),
    .pop_credit_o (pop_credit)
);

// add, normalize, special cases
fma_add_stage #(.OUT_CREDITS(OUT_CREDITS)) u_add
(
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_valid_i (head_valid),
    .head_item_i  (head_item),
    .out_credit_i (out_credit_i),
    .pop_o        (pop),
    .result_o     (result_o),
    .done_o       (done_o)
);

endmodule
